//--- logic/cpu_pkg.sv
package cpu_pkg;

  localparam int DATA_WIDTH = 8;

  typedef logic [DATA_WIDTH-1:0] word_t;

  typedef enum word_t {
    MOV, ADD, CMP, JMP, JC, JNC, JZ, JNZ, JS, JNS, NOP, HLT
  } opcode_t;

  typedef enum word_t {REG_A, ADDRESS_IMM, IMM, UNUSED} operand_t;

  typedef enum word_t {
    RESET_STAGE, FETCH_OPERATION, DECODE, FETCH_IMMEDIATE,
    EXECUTE, WRITE_REGISTER, WRITE_MEMORY, HALT
  } stage_t;

  // Bus phase, used by opcode fetch and memory write
  typedef enum word_t {IDL, BGN, END} phase_t;

  typedef enum logic [1:0] {MEMORY_STAY, MEMORY_READ, MEMORY_WRITE} mem_ctrl_t;

  localparam int FLAG_CARRY = 0;
  localparam int FLAG_ZERO  = 1;
  localparam int FLAG_SIGN  = 2;

  // Top two opcode bits
  localparam logic [1:0] GROUP_MOV   = 2'b00;
  localparam logic [1:0] GROUP_ADD   = 2'b01;
  localparam logic [1:0] GROUP_OTHER = 2'b11;

  // Operand field codes
  localparam logic [2:0] CODE_REG_A       = 3'b000;
  localparam logic [2:0] CODE_ADDRESS_IMM = 3'b010;
  localparam logic [2:0] CODE_IMM         = 3'b011;

  localparam word_t ENC_JMP = 8'b11_010_000;
  localparam word_t ENC_JC  = 8'b11_100_010;
  localparam word_t ENC_JNC = 8'b11_100_011;
  localparam word_t ENC_JZ  = 8'b11_100_100;
  localparam word_t ENC_JNZ = 8'b11_100_101;
  localparam word_t ENC_JS  = 8'b11_101_000;
  localparam word_t ENC_JNS = 8'b11_101_001;
  localparam word_t ENC_NOP = 8'b11_111_110;

endpackage

//--- logic/instruction_decoder.sv
module instruction_decoder import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  stage_t   stage,
  input  word_t    ope,
  output opcode_t  op,
  output operand_t src_kind,
  output operand_t dst_kind
);

  logic [1:0] group;
  operand_t   src_dec;
  operand_t   dst_dec;
  opcode_t    next_op;
  operand_t   next_src;
  operand_t   next_dst;

  function automatic operand_t code_kind(input logic [2:0] code);
    case (code)
      CODE_REG_A:       return REG_A;
      CODE_ADDRESS_IMM: return ADDRESS_IMM;
      CODE_IMM:         return IMM;
      default:          return UNUSED;
    endcase
  endfunction

  assign group   = ope[7:6];
  assign dst_dec = code_kind(ope[5:3]);
  assign src_dec = code_kind(ope[2:0]);

  always_comb begin
    next_op  = HLT;
    next_src = UNUSED;
    next_dst = UNUSED;
    if (group != GROUP_OTHER) begin
      // Destination is A or a memory byte, never an immediate
      if (src_dec != UNUSED && (dst_dec == REG_A || dst_dec == ADDRESS_IMM)) begin
        next_src = src_dec;
        next_dst = dst_dec;
        case (group)
          GROUP_MOV: next_op = MOV;
          GROUP_ADD: next_op = ADD;
          default:   next_op = CMP;
        endcase
      end
    end else begin
      case (ope)
        ENC_JMP: next_op = JMP;
        ENC_JC:  next_op = JC;
        ENC_JNC: next_op = JNC;
        ENC_JZ:  next_op = JZ;
        ENC_JNZ: next_op = JNZ;
        ENC_JS:  next_op = JS;
        ENC_JNS: next_op = JNS;
        ENC_NOP: next_op = NOP;
        default: next_op = HLT;
      endcase
      // Jumps carry a relative offset byte
      if (next_op != NOP && next_op != HLT) begin
        next_src = IMM;
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      op       <= NOP;
      src_kind <= UNUSED;
      dst_kind <= UNUSED;
    end else if (stage == DECODE) begin
      op       <= next_op;
      src_kind <= next_src;
      dst_kind <= next_dst;
    end
  end

endmodule

//--- logic/instruction_fetch.sv
module instruction_fetch import cpu_pkg::*; #(
  parameter word_t RESET_IP = '0
) (
  input  logic    CLOCK,
  input  logic    RESET,
  input  stage_t  stage,
  input  opcode_t op,
  input  word_t   imm,
  input  word_t   flags,
  input  word_t   read_bus,
  input  logic    operand_step,
  output word_t   ope,
  output word_t   ip,
  output logic    fetch_done
);

  phase_t phase;
  phase_t next_phase;
  logic   take_jump;
  word_t  next_ip;

  always_comb begin
    next_phase = IDL;
    if (stage == FETCH_OPERATION) begin
      case (phase)
        IDL:     next_phase = BGN;
        BGN:     next_phase = END;
        default: next_phase = IDL;
      endcase
    end
  end

  assign fetch_done = (stage == FETCH_OPERATION) && (phase == END);

  always_comb begin
    case (op)
      JMP:     take_jump = 1'b1;
      JC:      take_jump = flags[FLAG_CARRY];
      JNC:     take_jump = !flags[FLAG_CARRY];
      JZ:      take_jump = flags[FLAG_ZERO];
      JNZ:     take_jump = !flags[FLAG_ZERO];
      JS:      take_jump = flags[FLAG_SIGN];
      JNS:     take_jump = !flags[FLAG_SIGN];
      default: take_jump = 1'b0;
    endcase
  end

  always_comb begin
    next_ip = ip;
    // Halted program keeps its ip
    if (op != HLT) begin
      case (stage)
        FETCH_OPERATION: next_ip = (phase == END) ? ip + word_t'(1) : ip;
        FETCH_IMMEDIATE: next_ip = operand_step ? ip + word_t'(1) : ip;
        // ip already points past the offset byte here
        EXECUTE:         next_ip = take_jump ? ip + imm : ip;
        default:         next_ip = ip;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase <= IDL;
      ip    <= RESET_IP;
    end else begin
      phase <= next_phase;
      ip    <= next_ip;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (stage == FETCH_OPERATION && phase == BGN) begin
      ope <= read_bus;
    end
  end

endmodule

//--- logic/operand_fetch.sv
module operand_fetch import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  stage_t   stage,
  input  operand_t src_kind,
  input  operand_t dst_kind,
  input  word_t    ip,
  input  word_t    read_bus,
  output word_t    imm,
  output word_t    mem_src,
  output word_t    mem_dst,
  output word_t    dst_addr,
  output word_t    read_addr,
  output logic     operand_step,
  output logic     operands_done
);

  // The idle cycle doubles as the wait for the first byte, which is always at ip
  typedef enum logic [3:0] {
    SEQ_IDLE, LOAD_NONE, LOAD_IMM, LOAD_SRC_ADDR, WAIT_SRC, LOAD_SRC,
    WAIT_DST_ADDR, LOAD_DST_ADDR, WAIT_DST, LOAD_DST
  } seq_t;

  seq_t  seq;
  seq_t  next_seq;
  seq_t  after_src;
  word_t src_addr;

  assign after_src = (dst_kind == ADDRESS_IMM) ? WAIT_DST_ADDR : SEQ_IDLE;

  always_comb begin
    next_seq = SEQ_IDLE;
    if (stage == FETCH_IMMEDIATE) begin
      case (seq)
        SEQ_IDLE: begin
          case (src_kind)
            IMM:         next_seq = LOAD_IMM;
            ADDRESS_IMM: next_seq = LOAD_SRC_ADDR;
            default:     next_seq = (dst_kind == ADDRESS_IMM) ? LOAD_DST_ADDR : LOAD_NONE;
          endcase
        end
        LOAD_IMM:      next_seq = after_src;
        LOAD_SRC_ADDR: next_seq = WAIT_SRC;
        WAIT_SRC:      next_seq = LOAD_SRC;
        LOAD_SRC:      next_seq = after_src;
        WAIT_DST_ADDR: next_seq = LOAD_DST_ADDR;
        LOAD_DST_ADDR: next_seq = WAIT_DST;
        WAIT_DST:      next_seq = LOAD_DST;
        default:       next_seq = SEQ_IDLE;
      endcase
    end
  end

  // Last load of the instruction
  assign operands_done = (stage == FETCH_IMMEDIATE) && (seq != SEQ_IDLE) &&
                         (next_seq == SEQ_IDLE);

  assign operand_step = (seq == LOAD_IMM) || (seq == LOAD_SRC_ADDR) ||
                        (seq == LOAD_DST_ADDR);

  always_comb begin
    case (seq)
      WAIT_SRC, LOAD_SRC: read_addr = src_addr;
      WAIT_DST, LOAD_DST: read_addr = dst_addr;
      default:            read_addr = ip;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      seq <= SEQ_IDLE;
    end else begin
      seq <= next_seq;
    end
  end

  always_ff @(posedge CLOCK) begin
    case (seq)
      LOAD_IMM:      imm      <= read_bus;
      LOAD_SRC_ADDR: src_addr <= read_bus;
      LOAD_SRC:      mem_src  <= read_bus;
      LOAD_DST_ADDR: dst_addr <= read_bus;
      LOAD_DST:      mem_dst  <= read_bus;
      default:       ;
    endcase
  end

endmodule

//--- logic/execute_unit.sv
module execute_unit import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  stage_t   stage,
  input  opcode_t  op,
  input  operand_t src_kind,
  input  operand_t dst_kind,
  input  word_t    imm,
  input  word_t    mem_src,
  input  word_t    mem_dst,
  output word_t    result,
  output word_t    register_a,
  output word_t    flags
);

  word_t               src;
  word_t               orig_dst;
  word_t               neg_src;
  logic [DATA_WIDTH:0] alu_out;
  word_t               alu_flags;
  word_t               pending_flags;

  always_comb begin
    case (src_kind)
      REG_A:       src = register_a;
      ADDRESS_IMM: src = mem_src;
      IMM:         src = imm;
      default:     src = '0;
    endcase
  end

  assign orig_dst = (dst_kind == ADDRESS_IMM) ? mem_dst : register_a;
  assign neg_src  = ~src + word_t'(1);

  // Carry lands in the extra top bit
  always_comb begin
    case (op)
      ADD:     alu_out = {1'b0, orig_dst} + {1'b0, src};
      CMP:     alu_out = {1'b0, orig_dst} + {1'b0, neg_src};
      MOV:     alu_out = {1'b0, src};
      default: alu_out = {1'b0, orig_dst};
    endcase
  end

  always_comb begin
    alu_flags             = '0;
    alu_flags[FLAG_CARRY] = alu_out[DATA_WIDTH];
    alu_flags[FLAG_ZERO]  = (alu_out[DATA_WIDTH-1:0] == '0);
    alu_flags[FLAG_SIGN]  = alu_out[DATA_WIDTH-1];
  end

  always_ff @(posedge CLOCK) begin
    if (stage == EXECUTE) begin
      result        <= alu_out[DATA_WIDTH-1:0];
      pending_flags <= alu_flags;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      register_a <= '0;
      flags      <= '0;
    end else if (stage == WRITE_REGISTER) begin
      if (dst_kind == REG_A && op != CMP) begin
        register_a <= result;
      end
      if (op == ADD || op == CMP) begin
        flags <= pending_flags;
      end
    end
  end

endmodule

//--- logic/cycle_controller.sv
module cycle_controller import cpu_pkg::*; (
  input  logic      CLOCK,
  input  logic      RESET,
  input  opcode_t   op,
  input  operand_t  dst_kind,
  input  logic      fetch_done,
  input  logic      operands_done,
  input  word_t     ip,
  input  word_t     read_addr,
  input  word_t     dst_addr,
  input  word_t     result,
  output stage_t    stage,
  output word_t     addr_bus,
  output word_t     write_bus,
  output mem_ctrl_t ctrl_bus,
  output logic      halted
);

  stage_t next_stage;
  phase_t wr_phase;
  phase_t next_wr_phase;
  logic   store;

  // Only MOV and ADD write back to a memory destination
  assign store = (dst_kind == ADDRESS_IMM) && (op == MOV || op == ADD);

  always_comb begin
    case (stage)
      RESET_STAGE:     next_stage = FETCH_OPERATION;
      FETCH_OPERATION: next_stage = fetch_done ? DECODE : FETCH_OPERATION;
      DECODE:          next_stage = FETCH_IMMEDIATE;
      FETCH_IMMEDIATE: next_stage = operands_done ? EXECUTE : FETCH_IMMEDIATE;
      EXECUTE:         next_stage = (op == HLT) ? HALT : WRITE_REGISTER;
      WRITE_REGISTER:  next_stage = store ? WRITE_MEMORY : FETCH_OPERATION;
      WRITE_MEMORY:    next_stage = (wr_phase == END) ? FETCH_OPERATION : WRITE_MEMORY;
      default:         next_stage = HALT;
    endcase
  end

  always_comb begin
    next_wr_phase = IDL;
    if (stage == WRITE_MEMORY) begin
      case (wr_phase)
        IDL:     next_wr_phase = BGN;
        BGN:     next_wr_phase = END;
        default: next_wr_phase = IDL;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage    <= RESET_STAGE;
      wr_phase <= IDL;
    end else begin
      stage    <= next_stage;
      wr_phase <= next_wr_phase;
    end
  end

  always_comb begin
    case (stage)
      FETCH_OPERATION: addr_bus = ip;
      FETCH_IMMEDIATE: addr_bus = read_addr;
      WRITE_MEMORY:    addr_bus = dst_addr;
      default:         addr_bus = '0;
    endcase
  end

  always_comb begin
    case (stage)
      FETCH_OPERATION, FETCH_IMMEDIATE: ctrl_bus = MEMORY_READ;
      WRITE_MEMORY: ctrl_bus = (wr_phase == IDL) ? MEMORY_STAY : MEMORY_WRITE;
      default:      ctrl_bus = MEMORY_STAY;
    endcase
  end

  assign write_bus = (stage == WRITE_MEMORY) ? result : '0;
  assign halted    = (stage == HALT);

endmodule

//--- logic/cpu.sv
module cpu import cpu_pkg::*; #(
  parameter word_t RESET_IP = '0
) (
  input  logic      CLOCK,
  input  logic      RESET,
  input  word_t     read_bus,
  output word_t     addr_bus,
  output word_t     write_bus,
  output word_t     OUT,
  output mem_ctrl_t ctrl_bus,
  output logic      halted
);

  stage_t   stage;
  opcode_t  op;
  operand_t src_kind;
  operand_t dst_kind;
  word_t    ope;
  word_t    ip;
  logic     fetch_done;
  word_t    imm;
  word_t    mem_src;
  word_t    mem_dst;
  word_t    dst_addr;
  word_t    read_addr;
  logic     operand_step;
  logic     operands_done;
  word_t    result;
  word_t    flags;

  instruction_decoder instruction_decoder0 (.*);

  instruction_fetch #(.RESET_IP(RESET_IP)) instruction_fetch0 (.*);

  operand_fetch operand_fetch0 (.*);

  // A is shown directly on OUT
  execute_unit execute_unit0 (.*, .register_a(OUT));

  cycle_controller cycle_controller0 (.*);

endmodule

//--- verification/clock_gen.sv
module clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 4,
  parameter int SKEW         = 2
) (
  output logic CLOCK,
  output logic init_reset
);

  initial begin
    CLOCK = 1'b0;
    forever #(PERIOD / 2) CLOCK = ~CLOCK;
  end

  // Power-on reset, released just after an edge
  initial begin
    init_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLOCK);
    #(SKEW) init_reset = 1'b0;
  end

endmodule

//--- verification/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

  localparam int    SEED         = 62018;
  localparam int    SKEW         = 2;
  localparam int    RESET_CYCLES = 4;
  localparam int    MAX_STEPS    = 500;
  localparam word_t START_IP     = 8'h00;

  localparam logic [1:0] G_MOV = 2'b00;
  localparam logic [1:0] G_ADD = 2'b01;
  localparam logic [1:0] G_CMP = 2'b10;
  localparam logic [2:0] A_FIELD   = 3'b000;
  localparam logic [2:0] MEM_FIELD = 3'b010;
  localparam logic [2:0] IMM_FIELD = 3'b011;

  localparam word_t OPC_JMP = 8'b11_010_000;
  localparam word_t OPC_JC  = 8'b11_100_010;
  localparam word_t OPC_JNC = 8'b11_100_011;
  localparam word_t OPC_JZ  = 8'b11_100_100;
  localparam word_t OPC_JNZ = 8'b11_100_101;
  localparam word_t OPC_JS  = 8'b11_101_000;
  localparam word_t OPC_JNS = 8'b11_101_001;
  localparam word_t OPC_NOP = 8'b11_111_110;
  localparam word_t OPC_HLT = 8'b11_111_111;

  logic      CLOCK;
  logic      init_reset;
  logic      force_reset;
  logic      RESET;
  word_t     read_bus;
  word_t     addr_bus;
  word_t     write_bus;
  word_t     OUT;
  mem_ctrl_t ctrl_bus;
  logic      halted;

  word_t mem [256];
  word_t image [256];
  word_t ref_mem [256];
  word_t ref_a;
  logic  load_image;
  int    pc;
  int    ref_steps;
  int    errors;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  string test_name;
  event  run_started;
  event  check_done;

  clock_gen #(.PERIOD(40), .RESET_CYCLES(RESET_CYCLES), .SKEW(SKEW)) i_clock (
    .CLOCK(CLOCK),
    .init_reset(init_reset)
  );

  assign RESET = init_reset | force_reset;

  cpu #(.RESET_IP(START_IP)) i_dut (
    .CLOCK(CLOCK),
    .RESET(RESET),
    .read_bus(read_bus),
    .addr_bus(addr_bus),
    .write_bus(write_bus),
    .OUT(OUT),
    .ctrl_bus(ctrl_bus),
    .halted(halted)
  );

  // Memory model with combinational read
  assign read_bus = (ctrl_bus == MEMORY_READ) ? mem[addr_bus] : 8'h00;

  always @(posedge CLOCK) begin
    if (load_image) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] = image[i];
      end
    end else if (ctrl_bus == MEMORY_WRITE) begin
      mem[addr_bus] = write_bus;
    end
  end

  // Instruction-set model, runs on ref_mem from START_IP until HLT
  function automatic int execute_reference();
    int         steps;
    word_t      ip;
    word_t      opc;
    word_t      a;
    word_t      src;
    word_t      neg;
    word_t      dst_val;
    word_t      dst_addr;
    logic [8:0] sum;
    logic       c;
    logic       z;
    logic       s;
    logic       take;
    logic       stop;
    steps = 0;
    ip = START_IP;
    a = 8'h00;
    c = 1'b0;
    z = 1'b0;
    s = 1'b0;
    stop = 1'b0;
    while (!stop && steps < MAX_STEPS) begin
      opc = ref_mem[ip];
      ip = ip + 8'd1;
      steps++;
      if (opc[7:6] == 2'b11) begin
        take = 1'b0;
        case (opc)
          OPC_JMP: take = 1'b1;
          OPC_JC:  take = c;
          OPC_JNC: take = !c;
          OPC_JZ:  take = z;
          OPC_JNZ: take = !z;
          OPC_JS:  take = s;
          OPC_JNS: take = !s;
          OPC_NOP: ;
          default: stop = 1'b1;
        endcase
        if (!stop && opc != OPC_NOP) begin
          // Offset counts from the byte after the jump
          src = ref_mem[ip];
          ip = ip + 8'd1;
          if (take) begin
            ip = ip + src;
          end
        end
      end else if (!((opc[2:0] == A_FIELD || opc[2:0] == MEM_FIELD || opc[2:0] == IMM_FIELD) &&
                     (opc[5:3] == A_FIELD || opc[5:3] == MEM_FIELD))) begin
        stop = 1'b1;
      end else begin
        case (opc[2:0])
          A_FIELD:   src = a;
          MEM_FIELD: src = ref_mem[ref_mem[ip]];
          default:   src = ref_mem[ip];
        endcase
        if (opc[2:0] != A_FIELD) begin
          ip = ip + 8'd1;
        end
        dst_addr = 8'h00;
        dst_val = a;
        if (opc[5:3] == MEM_FIELD) begin
          dst_addr = ref_mem[ip];
          ip = ip + 8'd1;
          dst_val = ref_mem[dst_addr];
        end
        neg = ~src + 8'd1;
        case (opc[7:6])
          G_MOV:   sum = {1'b0, src};
          G_ADD:   sum = {1'b0, dst_val} + {1'b0, src};
          default: sum = {1'b0, dst_val} + {1'b0, neg};
        endcase
        if (opc[7:6] != G_MOV) begin
          c = sum[8];
          z = (sum[7:0] == 8'h00);
          s = sum[7];
        end
        // CMP only updates the flags
        if (opc[7:6] != G_CMP) begin
          if (opc[5:3] == MEM_FIELD) begin
            ref_mem[dst_addr] = sum[7:0];
          end else begin
            a = sum[7:0];
          end
        end
      end
    end
    ref_a = a;
    return steps;
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic clear_image();
    for (int i = 0; i < 256; i++) begin
      image[i] = 8'((i * 37 + 11) % 256);
    end
    pc = 0;
  endtask

  task automatic put(input word_t value);
    image[pc] = value;
    pc++;
  endtask

  task automatic put_alu(input logic [1:0] grp, input logic [2:0] dst, input logic [2:0] src,
                         input word_t src_byte, input word_t dst_byte);
    put({grp, dst, src});
    if (src != A_FIELD) begin
      put(src_byte);
    end
    if (dst == MEM_FIELD) begin
      put(dst_byte);
    end
  endtask

  function automatic word_t jump_code(input int j);
    case (j)
      0:       return OPC_JC;
      1:       return OPC_JNC;
      2:       return OPC_JZ;
      3:       return OPC_JNZ;
      4:       return OPC_JS;
      default: return OPC_JNS;
    endcase
  endfunction

  task automatic build_countdown(input word_t count);
    int loop_pc;
    clear_image();
    put_alu(G_MOV, MEM_FIELD, IMM_FIELD, count, 8'hC0);
    put_alu(G_MOV, MEM_FIELD, IMM_FIELD, 8'h00, 8'hC1);
    loop_pc = pc;
    put_alu(G_MOV, A_FIELD, MEM_FIELD, 8'hC0, 8'h00);
    put_alu(G_ADD, MEM_FIELD, A_FIELD, 8'h00, 8'hC1);
    put_alu(G_MOV, A_FIELD, IMM_FIELD, 8'hFF, 8'h00);
    put_alu(G_ADD, MEM_FIELD, A_FIELD, 8'h00, 8'hC0);
    put(OPC_JNZ);
    put(8'(loop_pc - (pc + 1)));
    put_alu(G_MOV, A_FIELD, MEM_FIELD, 8'hC1, 8'h00);
    put(OPC_HLT);
  endtask

  task automatic build_random();
    int         n;
    logic [2:0] src;
    logic [2:0] dst;
    logic [1:0] grp;
    clear_image();
    n = 4 + int'($urandom_range(0, 6));
    for (int k = 0; k < n; k++) begin
      grp = 2'($urandom_range(0, 2));
      dst = ($urandom_range(0, 1) != 0) ? MEM_FIELD : A_FIELD;
      case ($urandom_range(0, 2))
        0:       src = A_FIELD;
        1:       src = MEM_FIELD;
        default: src = IMM_FIELD;
      endcase
      // Few data addresses, so stores and loads overlap
      put_alu(grp, dst, src, (src == MEM_FIELD) ? 8'($urandom_range(128, 135)) : 8'($urandom),
              8'($urandom_range(128, 135)));
    end
    put(OPC_HLT);
  endtask

  // Holds reset while the image is loaded and checks the idle outputs
  task automatic start_program();
    force_reset = 1'b1;
    load_image = 1'b1;
    repeat (RESET_CYCLES) begin
      @(posedge CLOCK);
      #(SKEW);
      load_image = 1'b0;
      if (ctrl_bus !== MEMORY_STAY) begin
        $display("[ERROR] %0t: %s ctrl_bus is %0d in reset", $time, test_name, ctrl_bus);
        count_error();
      end
      if (halted !== 1'b0) begin
        $display("[ERROR] %0t: %s halted is high in reset", $time, test_name);
        count_error();
      end
      if (OUT !== 8'h00) begin
        $display("[ERROR] %0t: %s OUT is %0h in reset, expected 0", $time, test_name, OUT);
        count_error();
      end
    end
    force_reset = 1'b0;
  endtask

  task automatic launch(input string name);
    test_name = name;
    test_errors = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = image[i];
    end
    ref_steps = execute_reference();
    start_program();
    -> run_started;
    @(check_done);
  endtask

  always begin
    int limit;
    int cycles;
    @(run_started);
    limit = 20 * (ref_steps + 1);
    cycles = 0;
    while (halted !== 1'b1 && cycles < limit) begin
      @(posedge CLOCK);
      #(SKEW);
      cycles++;
    end
    if (halted !== 1'b1) begin
      $display("%s: CPU did not halt within %0d cycles", test_name, limit);
      $display("TEST FAIL");
      $finish;
    end else begin
      if (OUT !== ref_a) begin
        $display("[ERROR] %0t: %s OUT is %0h, expected %0h", $time, test_name, OUT, ref_a);
        count_error();
      end
      for (int i = 0; i < 256; i++) begin
        if (mem[i] !== ref_mem[i]) begin
          $display("[ERROR] %0t: %s mem[%0h] is %0h, expected %0h", $time, test_name, i,
                   mem[i], ref_mem[i]);
          count_error();
        end
      end
      tests_run++;
      if (test_errors != 0) begin
        tests_failed++;
      end
      $display("%s: %s after %0d cycles, %0d errors", test_name,
               (test_errors == 0) ? "passed" : "failed", cycles, test_errors);
      -> check_done;
    end
  end

  initial begin
    word_t marker;
    void'($urandom(SEED));
    force_reset = 1'b1;
    load_image = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    clear_image();

    put_alu(G_MOV, A_FIELD, IMM_FIELD, 8'($urandom), 8'h00);
    put_alu(G_ADD, A_FIELD, IMM_FIELD, 8'($urandom), 8'h00);
    put_alu(G_ADD, A_FIELD, IMM_FIELD, 8'hC7, 8'h00);
    put_alu(G_CMP, A_FIELD, IMM_FIELD, 8'($urandom), 8'h00);
    put(OPC_NOP);
    put_alu(G_ADD, A_FIELD, A_FIELD, 8'h00, 8'h00);
    put(OPC_HLT);
    launch("immediates into A");

    clear_image();
    put_alu(G_MOV, A_FIELD, IMM_FIELD, 8'h3C, 8'h00);
    put_alu(G_MOV, MEM_FIELD, A_FIELD, 8'h00, 8'h90);
    put_alu(G_MOV, MEM_FIELD, IMM_FIELD, 8'h81, 8'h91);
    put_alu(G_MOV, A_FIELD, IMM_FIELD, 8'h05, 8'h00);
    put_alu(G_ADD, A_FIELD, MEM_FIELD, 8'h90, 8'h00);
    put_alu(G_ADD, MEM_FIELD, A_FIELD, 8'h00, 8'h91);
    put_alu(G_ADD, MEM_FIELD, MEM_FIELD, 8'h92, 8'h93);
    put_alu(G_MOV, A_FIELD, MEM_FIELD, 8'h91, 8'h00);
    put(OPC_HLT);
    launch("store and load back");

    // 5-5 sets carry and zero, 3-9 sets sign only
    clear_image();
    for (int j = 0; j < 6; j++) begin
      for (int p = 0; p < 2; p++) begin
        marker = 8'(160 + 4 * j + 2 * p);
        put_alu(G_MOV, A_FIELD, IMM_FIELD, (p != 0) ? 8'd3 : 8'd5, 8'h00);
        put_alu(G_CMP, A_FIELD, IMM_FIELD, (p != 0) ? 8'd9 : 8'd5, 8'h00);
        put(jump_code(j));
        put(8'd3);
        put_alu(G_MOV, MEM_FIELD, IMM_FIELD, 8'hAA, marker);
        put_alu(G_MOV, MEM_FIELD, IMM_FIELD, 8'(2 * j + p), marker + 8'd1);
      end
    end
    put(OPC_HLT);
    launch("conditional jumps");

    build_countdown(8'd10);
    launch("countdown loop");

    for (int k = 0; k < 20; k++) begin
      build_random();
      launch($sformatf("random program %0d", k));
    end

    // Cut the loop short, then rerun from a fresh image
    build_countdown(8'd12);
    test_name = "reset mid-program";
    start_program();
    repeat (40) begin
      @(posedge CLOCK);
    end
    #(SKEW);
    launch("reset mid-program");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
logic/cpu_pkg.sv
logic/instruction_decoder.sv
logic/instruction_fetch.sv
logic/operand_fetch.sv
logic/execute_unit.sv
logic/cycle_controller.sv
logic/cpu.sv
verification/clock_gen.sv
verification/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build the CPU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module cpu_tb -f all.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0
